// ==== list.f ====
+incdir+logic
logic/sfm_pkg.sv
logic/sfm_red_minmax.sv
logic/sfm_glob_minmax.sv
logic/sfm_max_tracker.sv
test/tb_sfm_max_tracker.sv

// ==== logic/sfm_config.svh ====
/*
 * softmax extremum stage configuration: number format, lane count
 * and depth of the reduction pipeline
 */
`ifndef SFM_CONFIG_SVH
`define SFM_CONFIG_SVH

// half precision by default
`define SFM_EXP_BITS 5
`define SFM_MAN_BITS 10

// sign, exponent and mantissa
`define SFM_FP_WIDTH (1 + `SFM_EXP_BITS + `SFM_MAN_BITS)

// lanes per input vector
`define SFM_VECT_WIDTH 4

// registers in the reduction tree, at most clog2 of the lane count
`define SFM_NUM_REGS 2

`endif

// ==== logic/sfm_glob_minmax.sv ====
/*
 * sfm_glob_minmax: holds the running extremum over all vectors and
 * flags when a reduced vector replaces it
 */
`timescale 1ns/1ns
`default_nettype none

`include "sfm_config.svh"

module sfm_glob_minmax
    import sfm_pkg::*;
#(
    parameter int unsigned VECT_WIDTH = `SFM_VECT_WIDTH,
    parameter int unsigned NUM_REGS   = `SFM_NUM_REGS
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      clear_i,
    input  wire logic                      enable_i,
    input  wire logic                      valid_i,
    input  wire logic                      ready_i,
    input  wire min_max_mode_t             operation_i,
    input  wire logic [VECT_WIDTH-1:0]     strb_i,
    input  wire fp_word_u [VECT_WIDTH-1:0] vect_i,
    input  wire fp_word_u                  load_i,
    input  wire logic                      load_en_i,
    output fp_word_u                       cur_minmax_o,
    output fp_word_u                       new_minmax_o,
    output logic                           new_flg_o,
    output logic                           valid_o,
    output logic                           ready_o
);

    fp_word_u red_res;
    fp_word_u minmax_q;
    fp_word_u start_val;
    logic     red_strb;
    logic     red_valid;
    logic     new_flg;
    logic     update;
    logic     init_q;
    logic     valid_q;

    sfm_red_minmax #(
        .VECT_WIDTH (VECT_WIDTH),
        .NUM_REGS   (NUM_REGS)
    ) i_red_minmax (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .clear_i  (clear_i),
        .enable_i (enable_i),
        .valid_i  (valid_i),
        .ready_i  (ready_i),
        .mode_i   (operation_i),
        .strb_i   (strb_i),
        .vect_i   (vect_i),
        .res_o    (red_res),
        .strb_o   (red_strb),
        .valid_o  (red_valid),
        .ready_o  (ready_o)
    );

    // until the first load or update the held value is the start infinity
    assign start_val    = (operation_i == MAX) ? FP_NEG_INF : FP_POS_INF;
    assign cur_minmax_o = init_q ? start_val : minmax_q;

    assign new_flg      = red_strb & fp_beyond(operation_i, red_res, cur_minmax_o);
    assign update       = red_valid & new_flg & ready_i;
    assign new_minmax_o = new_flg ? red_res : cur_minmax_o;
    assign new_flg_o    = new_flg;
    assign valid_o      = valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q  <= 1'b1;
            valid_q <= 1'b0;
        end else if (clear_i) begin
            init_q  <= 1'b1;
            valid_q <= 1'b0;
        end else begin
            if (load_en_i || update) begin
                init_q <= 1'b0;
            end
            // sticky once any result has left the tree
            if (red_valid) begin
                valid_q <= 1'b1;
            end
        end
    end

    // a software load overrides an update in the same cycle
    always_ff @(posedge clk_i) begin
        if (load_en_i) begin
            minmax_q <= load_i;
        end else if (update) begin
            minmax_q <= red_res;
        end
    end

    a_update_advances : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (update && !load_en_i && !clear_i) |=>
            fp_beyond($past(operation_i), cur_minmax_o, $past(cur_minmax_o)));

    a_no_regress : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!load_en_i && !clear_i) |=>
            !fp_beyond($past(operation_i), $past(cur_minmax_o), cur_minmax_o));

endmodule

`default_nettype wire

// ==== logic/sfm_max_tracker.sv ====
/*
 * sfm_max_tracker: top level of the running extremum stage, built
 * for the configured format, lane count and pipeline depth
 */
`timescale 1ns/1ns
`default_nettype none

`include "sfm_config.svh"

module sfm_max_tracker
    import sfm_pkg::*;
(
    input  wire logic                           clk_i,
    input  wire logic                           rst_ni,
    input  wire logic                           clear_i,
    input  wire logic                           enable_i,
    input  wire logic                           valid_i,
    input  wire logic                           ready_i,
    input  wire min_max_mode_t                  operation_i,
    input  wire logic [`SFM_VECT_WIDTH-1:0]     strb_i,
    input  wire fp_word_u [`SFM_VECT_WIDTH-1:0] vect_i,
    input  wire fp_word_u                       load_i,
    input  wire logic                           load_en_i,
    output fp_word_u                            cur_minmax_o,
    output fp_word_u                            new_minmax_o,
    output logic                                new_flg_o,
    output logic                                valid_o,
    output logic                                ready_o
);

    // results appear SFM_NUM_REGS cycles after a vector is accepted
    sfm_glob_minmax #(
        .VECT_WIDTH (`SFM_VECT_WIDTH),
        .NUM_REGS   (`SFM_NUM_REGS)
    ) i_glob_minmax (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear_i),
        .enable_i     (enable_i),
        .valid_i      (valid_i),
        .ready_i      (ready_i),
        .operation_i  (operation_i),
        .strb_i       (strb_i),
        .vect_i       (vect_i),
        .load_i       (load_i),
        .load_en_i    (load_en_i),
        .cur_minmax_o (cur_minmax_o),
        .new_minmax_o (new_minmax_o),
        .new_flg_o    (new_flg_o),
        .valid_o      (valid_o),
        .ready_o      (ready_o)
    );

endmodule

`default_nettype wire

// ==== logic/sfm_pkg.sv ====
/*
 * sfm_pkg: shared types, infinity constants and ordering helpers
 * for the softmax extremum stage
 */
`default_nettype none

`include "sfm_config.svh"

package sfm_pkg;

    // which extremum is tracked
    typedef enum logic {
        MAX = 1'b0,
        MIN = 1'b1
    } min_max_mode_t;

    typedef struct packed {
        logic                     sign;
        logic [`SFM_EXP_BITS-1:0] exponent;
        logic [`SFM_MAN_BITS-1:0] mantissa;
    } fp_fields_t;

    // one word, seen as plain bits or as its fields
    typedef union packed {
        logic [`SFM_FP_WIDTH-1:0] raw;
        fp_fields_t               fields;
    } fp_word_u;

    localparam fp_word_u FP_POS_INF =
        fp_word_u'({1'b0, {`SFM_EXP_BITS{1'b1}}, {`SFM_MAN_BITS{1'b0}}});
    localparam fp_word_u FP_NEG_INF =
        fp_word_u'({1'b1, {`SFM_EXP_BITS{1'b1}}, {`SFM_MAN_BITS{1'b0}}});

    function automatic logic fp_is_nan(fp_word_u a);
        return (a.fields.exponent == '1) && (a.fields.mantissa != '0);
    endfunction

    // a > b on non-NaN words, the two zeros compare equal
    function automatic logic fp_gt(fp_word_u a, fp_word_u b);
        logic [`SFM_FP_WIDTH-2:0] mag_a;
        logic [`SFM_FP_WIDTH-2:0] mag_b;
        mag_a = {a.fields.exponent, a.fields.mantissa};
        mag_b = {b.fields.exponent, b.fields.mantissa};
        if ((mag_a == '0) && (mag_b == '0)) begin
            return 1'b0;
        end
        if (a.fields.sign != b.fields.sign) begin
            return !a.fields.sign;
        end
        // negative words order by falling magnitude
        return a.fields.sign ? (mag_a < mag_b) : (mag_a > mag_b);
    endfunction

    function automatic logic fp_lt(fp_word_u a, fp_word_u b);
        return fp_gt(b, a);
    endfunction

    // a lies strictly past b in the direction of the tracked extremum
    function automatic logic fp_beyond(min_max_mode_t mode, fp_word_u a, fp_word_u b);
        return (mode == MAX) ? fp_gt(a, b) : fp_lt(a, b);
    endfunction

endpackage

`default_nettype wire

// ==== logic/sfm_red_minmax.sv ====
/*
 * sfm_red_minmax: pipelined compare-select tree that reduces the
 * strobed lanes of a vector to their maximum or minimum
 */
`timescale 1ns/1ns
`default_nettype none

`include "sfm_config.svh"

module sfm_red_minmax
    import sfm_pkg::*;
#(
    parameter int unsigned VECT_WIDTH = `SFM_VECT_WIDTH,
    parameter int unsigned NUM_REGS   = `SFM_NUM_REGS
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      clear_i,
    input  wire logic                      enable_i,
    input  wire logic                      valid_i,
    input  wire logic                      ready_i,
    input  wire min_max_mode_t             mode_i,
    input  wire logic [VECT_WIDTH-1:0]     strb_i,
    input  wire fp_word_u [VECT_WIDTH-1:0] vect_i,
    output fp_word_u                       res_o,
    output logic                           strb_o,
    output logic                           valid_o,
    output logic                           ready_o
);

    // lanes are padded up to a power of two, NUM_REGS must not exceed LEVELS
    localparam int unsigned LEVELS = (VECT_WIDTH > 1) ? $clog2(VECT_WIDTH) : 0;
    localparam int unsigned PAD    = 1 << LEVELS;

    // stage l feeds tree level l, the last stage carries the result
    fp_word_u [PAD-1:0] st_val  [LEVELS+1];
    logic     [PAD-1:0] st_strb [LEVELS+1];
    logic               st_vld  [LEVELS+1];

    fp_word_u [PAD-1:0] lane_val;
    logic     [PAD-1:0] lane_strb;
    logic               stage_en;

    // the whole tree stalls together
    assign stage_en = enable_i & ready_i;
    assign ready_o  = ready_i;

    // NaN lanes and lanes of an invalid vector drop out here
    always_comb begin
        lane_val  = '0;
        lane_strb = '0;
        for (int i = 0; i < VECT_WIDTH; i++) begin
            lane_val[i]  = vect_i[i];
            lane_strb[i] = valid_i & strb_i[i] & ~fp_is_nan(vect_i[i]);
        end
    end

    assign st_val[0]  = lane_val;
    assign st_strb[0] = lane_strb;
    assign st_vld[0]  = valid_i & enable_i;

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int unsigned NODES = PAD >> (l + 1);

        fp_word_u [PAD-1:0] node_val;
        logic     [PAD-1:0] node_strb;

        // right child wins only when live and strictly beyond the left one
        always_comb begin
            node_val  = '0;
            node_strb = '0;
            for (int n = 0; n < NODES; n++) begin
                if (st_strb[l][2*n+1] && (!st_strb[l][2*n] ||
                        fp_beyond(mode_i, st_val[l][2*n+1], st_val[l][2*n]))) begin
                    node_val[n] = st_val[l][2*n+1];
                end else begin
                    node_val[n] = st_val[l][2*n];
                end
                node_strb[n] = st_strb[l][2*n] | st_strb[l][2*n+1];
            end
        end

        if (l < NUM_REGS) begin : g_reg
            fp_word_u [PAD-1:0] val_q;
            logic     [PAD-1:0] strb_q;
            logic               vld_q;

            always_ff @(posedge clk_i or negedge rst_ni) begin
                if (!rst_ni) begin
                    strb_q <= '0;
                    vld_q  <= 1'b0;
                end else if (clear_i) begin
                    strb_q <= '0;
                    vld_q  <= 1'b0;
                end else if (stage_en) begin
                    strb_q <= node_strb;
                    vld_q  <= st_vld[l];
                end
            end

            always_ff @(posedge clk_i) begin
                if (stage_en) begin
                    val_q <= node_val;
                end
            end

            assign st_val[l+1]  = val_q;
            assign st_strb[l+1] = strb_q;
            assign st_vld[l+1]  = vld_q;
        end else begin : g_comb
            assign st_val[l+1]  = node_val;
            assign st_strb[l+1] = node_strb;
            assign st_vld[l+1]  = st_vld[l];
        end
    end

    assign res_o   = st_val[LEVELS][0];
    assign strb_o  = st_strb[LEVELS][0];
    assign valid_o = st_vld[LEVELS];

    // NaN lanes masked at the input never surface through the pipeline
    a_res_not_nan : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && strb_o) |-> !fp_is_nan(res_o));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the extremum stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
    --top-module tb_sfm_max_tracker -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// ==== test/tb_sfm_max_tracker.sv ====
/*
 * testbench for the running extremum stage: directed tests checked
 * against a reference model of the held maximum or minimum
 */
`timescale 1ns/1ns
`default_nettype none

`include "sfm_config.svh"

module tb_sfm_max_tracker
    import sfm_pkg::*;
();

    localparam int          VW  = `SFM_VECT_WIDTH;
    localparam int          LAT = `SFM_NUM_REGS;
    // reset, about 120 vectors of LAT + 1 cycles each, then a margin
    localparam int unsigned CYCLE_LIMIT = 8 + 120 * (LAT + 1) + 100;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   clear_i;
    logic                   enable_i;
    logic                   valid_i;
    logic                   ready_i;
    logic                   load_en_i;
    min_max_mode_t          operation_i;
    logic [VW-1:0]          strb_i;
    fp_word_u [VW-1:0]      vect_i;
    fp_word_u               load_i;
    fp_word_u               cur_minmax_o;
    fp_word_u               new_minmax_o;
    logic                   new_flg_o;
    logic                   valid_o;
    logic                   ready_o;

    fp_word_u               ref_val;
    int unsigned            cycles;

    sfm_max_tracker i_dut (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("TEST FAILED");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic check_word(input string name, input fp_word_u act, input fp_word_u exp);
        if (act.raw !== exp.raw) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp.raw, act.raw);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic ahead_of(min_max_mode_t m, fp_word_u a, fp_word_u b);
        return (m == MAX) ? fp_gt(a, b) : fp_lt(a, b);
    endfunction

    // sign chosen so that an unfiltered NaN would win the compare
    function automatic fp_word_u nan_word(input min_max_mode_t m);
        fp_word_u w;
        w                    = FP_POS_INF;
        w.fields.sign        = (m == MIN);
        w.fields.mantissa[0] = 1'b1;
        return w;
    endfunction

    function automatic fp_word_u rand_finite();
        logic [31:0] r;
        fp_word_u    w;
        w.raw = '1;
        while (w.fields.exponent == '1) begin
            r     = $urandom();
            w.raw = r[`SFM_FP_WIDTH-1:0];
        end
        return w;
    endfunction

    // extremum of the live lanes against the model's held value
    task automatic predict(input fp_word_u [VW-1:0] v, input logic [VW-1:0] s,
                           output fp_word_u cand, output logic flg);
        fp_word_u best;
        logic     found;
        found = 1'b0;
        best  = ref_val;
        for (int i = 0; i < VW; i++) begin
            if (s[i] && !fp_is_nan(v[i]) && (!found || ahead_of(operation_i, v[i], best))) begin
                best  = v[i];
                found = 1'b1;
            end
        end
        flg  = found && ahead_of(operation_i, best, ref_val);
        cand = flg ? best : ref_val;
    endtask

    // one vector in, candidate after LAT cycles, held value one cycle later
    task automatic send_vector(input fp_word_u [VW-1:0] v, input logic [VW-1:0] s,
                               input logic do_load, input fp_word_u ld);
        fp_word_u cand;
        logic     flg;
        predict(v, s, cand, flg);
        vect_i  = v;
        strb_i  = s;
        valid_i = 1'b1;
        repeat (LAT) begin
            step();
            valid_i = 1'b0;
        end
        check_bit("new_flg_o", new_flg_o, flg);
        check_word("new_minmax_o", new_minmax_o, cand);
        load_en_i = do_load;
        load_i    = ld;
        step();
        load_en_i = 1'b0;
        ref_val   = do_load ? ld : cand;
        check_word("cur_minmax_o", cur_minmax_o, ref_val);
        check_bit("valid_o", valid_o, 1'b1);
    endtask

    // masked lanes carry the value that would win if they were live
    task automatic random_run(input int count, input logic masked);
        fp_word_u [VW-1:0] v;
        logic [VW-1:0]     s;
        logic [31:0]       r;
        for (int n = 0; n < count; n++) begin
            s = '1;
            for (int i = 0; i < VW; i++) begin
                r    = $urandom();
                v[i] = rand_finite();
                if (masked && !r[0]) begin
                    s[i] = 1'b0;
                    v[i] = (operation_i == MAX) ? FP_POS_INF : FP_NEG_INF;
                end else if (masked && r[2:1] == 2'b00) begin
                    v[i] = nan_word(operation_i);
                end
            end
            send_vector(v, s, 1'b0, '0);
        end
    endtask

    task automatic restart(input min_max_mode_t m);
        operation_i = m;
        clear_i     = 1'b1;
        step();
        clear_i = 1'b0;
        ref_val = (m == MAX) ? FP_NEG_INF : FP_POS_INF;
        check_word("cur_minmax_o", cur_minmax_o, ref_val);
        check_bit("valid_o", valid_o, 1'b0);
    endtask

    // two vectors in flight, stall with the first one at the output
    task automatic stall_test();
        fp_word_u [VW-1:0] a;
        fp_word_u [VW-1:0] b;
        fp_word_u          cand;
        logic              flg;
        // a holds negative lanes and b positive ones, so both replace the held value
        for (int i = 0; i < VW; i++) begin
            a[i]             = rand_finite();
            b[i]             = rand_finite();
            a[i].fields.sign = 1'b1;
            b[i].fields.sign = 1'b0;
        end
        strb_i  = '1;
        vect_i  = a;
        valid_i = 1'b1;
        step();
        vect_i = b;
        repeat (LAT - 1) step();
        valid_i = 1'b0;
        ready_i = 1'b0;
        predict(a, '1, cand, flg);
        repeat (5) begin
            check_bit("ready_o", ready_o, 1'b0);
            check_bit("new_flg_o", new_flg_o, flg);
            check_word("new_minmax_o", new_minmax_o, cand);
            check_word("cur_minmax_o", cur_minmax_o, ref_val);
            step();
        end
        ready_i = 1'b1;
        check_bit("ready_o", ready_o, 1'b1);
        step();
        ref_val = cand;
        check_word("cur_minmax_o", cur_minmax_o, ref_val);
        predict(b, '1, cand, flg);
        check_bit("new_flg_o", new_flg_o, flg);
        check_word("new_minmax_o", new_minmax_o, cand);
        step();
        ref_val = cand;
        check_word("cur_minmax_o", cur_minmax_o, ref_val);
    endtask

    initial begin
        fp_word_u [VW-1:0] v;
        fp_word_u          ld;
        void'($urandom(32'h82b7ecb2));
        cycles      = 0;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        clear_i     = 1'b0;
        enable_i    = 1'b1;
        valid_i     = 1'b0;
        ready_i     = 1'b1;
        load_en_i   = 1'b0;
        operation_i = MAX;
        strb_i      = '0;
        vect_i      = '0;
        load_i      = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        check_word("cur_minmax_o", cur_minmax_o, FP_NEG_INF);
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("new_flg_o", new_flg_o, 1'b0);

        restart(MAX);
        random_run(40, 1'b0);
        restart(MIN);
        random_run(40, 1'b0);

        // strobes and NaN, then an all-NaN vector and one with no lane strobed
        random_run(20, 1'b1);
        for (int i = 0; i < VW; i++) begin
            v[i] = nan_word(operation_i);
        end
        send_vector(v, '1, 1'b0, '0);
        for (int i = 0; i < VW; i++) begin
            v[i] = (operation_i == MAX) ? FP_POS_INF : FP_NEG_INF;
        end
        send_vector(v, '0, 1'b0, '0);

        // a plain load, then a load that wins over an update in its cycle
        restart(MAX);
        ld        = rand_finite();
        load_i    = ld;
        load_en_i = 1'b1;
        step();
        load_en_i = 1'b0;
        ref_val   = ld;
        check_word("cur_minmax_o", cur_minmax_o, ref_val);
        for (int i = 0; i < VW; i++) begin
            v[i] = rand_finite();
        end
        v[1] = FP_POS_INF;
        send_vector(v, '1, 1'b1, rand_finite());
        random_run(4, 1'b0);

        restart(MAX);
        stall_test();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
